//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
id_pkg.sv
id_decoder.sv
id_regfile.sv
id_operand_mux.sv
id_multicycle_fsm.sv
id_stage.sv
id_stage_props.sv
tb_id_stage.sv

//--- id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
	input  id_pkg::instr_t     instr_rdata_i,
	output logic               illegal_o,
	output id_pkg::reg_addr_t  raddr_a_o,
	output id_pkg::reg_addr_t  raddr_b_o,
	output id_pkg::reg_addr_t  waddr_o,
	output logic               rf_we_o,
	output id_pkg::rf_wd_sel_e wdata_sel_o,
	output id_pkg::alu_op_e    alu_operator_o,
	output id_pkg::op_a_sel_e  op_a_sel_o,
	output id_pkg::op_b_sel_e  op_b_sel_o,
	output id_pkg::imm_b_sel_e imm_b_sel_o,
	output id_pkg::xlen_t      imm_i_o,
	output id_pkg::xlen_t      imm_s_o,
	output id_pkg::xlen_t      imm_b_o,
	output id_pkg::xlen_t      imm_u_o,
	output id_pkg::xlen_t      imm_j_o,
	output logic               data_req_o,
	output logic               data_we_o,
	output id_pkg::data_type_t data_type_o,
	output logic               data_sign_ext_o,
	output logic               branch_o,
	output logic               jump_o
);
	import id_pkg::*;

	opcode_t    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	instr_t     instr;

	assign instr  = instr_rdata_i;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign raddr_a_o = instr[19:15];
	assign raddr_b_o = instr[24:20];
	assign waddr_o   = instr[11:7];

	assign imm_i_o = {{20{instr[31]}}, instr[31:20]};
	assign imm_s_o = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b_o = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u_o = {instr[31:12], 12'b0};
	assign imm_j_o = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		illegal_o       = 1'b0;
		rf_we_o         = 1'b0;
		wdata_sel_o     = RF_WD_EX;
		alu_operator_o  = ALU_ADD;
		op_a_sel_o      = OP_A_REG_A;
		op_b_sel_o      = OP_B_IMM;
		imm_b_sel_o     = IMM_B_I;
		data_req_o      = 1'b0;
		data_we_o       = 1'b0;
		data_type_o     = DATA_WORD;
		data_sign_ext_o = 1'b0;
		branch_o        = 1'b0;
		jump_o          = 1'b0;

		case (opcode)
			OPCODE_LUI: begin
				op_a_sel_o  = OP_A_ZERO;
				imm_b_sel_o = IMM_B_U;
				rf_we_o     = 1'b1;
			end
			OPCODE_AUIPC: begin
				op_a_sel_o  = OP_A_CURRPC;
				imm_b_sel_o = IMM_B_U;
				rf_we_o     = 1'b1;
			end
			// Return address is PC + 4, formed by the ALU.
			OPCODE_JAL, OPCODE_JALR: begin
				op_a_sel_o  = OP_A_CURRPC;
				imm_b_sel_o = IMM_B_INCR_PC;
				rf_we_o     = 1'b1;
				jump_o      = 1'b1;
				illegal_o   = (opcode == OPCODE_JALR) && (funct3 != 3'b000);
			end
			OPCODE_BRANCH: begin
				op_b_sel_o  = OP_B_REG_B;
				imm_b_sel_o = IMM_B_B;
				branch_o    = 1'b1;
				case (funct3)
					3'b000:  alu_operator_o = ALU_EQ;
					3'b001:  alu_operator_o = ALU_NE;
					3'b100:  alu_operator_o = ALU_LT;
					3'b101:  alu_operator_o = ALU_GE;
					3'b110:  alu_operator_o = ALU_LTU;
					3'b111:  alu_operator_o = ALU_GEU;
					default: illegal_o = 1'b1;
				endcase
			end
			OPCODE_LOAD: begin
				data_req_o      = 1'b1;
				rf_we_o         = 1'b1;
				wdata_sel_o     = RF_WD_LSU;
				data_sign_ext_o = ~funct3[2];
				case (funct3)
					3'b000, 3'b100: data_type_o = DATA_BYTE;
					3'b001, 3'b101: data_type_o = DATA_HALF;
					3'b010:         data_type_o = DATA_WORD;
					default:        illegal_o = 1'b1;
				endcase
			end
			OPCODE_STORE: begin
				data_req_o  = 1'b1;
				data_we_o   = 1'b1;
				imm_b_sel_o = IMM_B_S;
				case (funct3)
					3'b000:  data_type_o = DATA_BYTE;
					3'b001:  data_type_o = DATA_HALF;
					3'b010:  data_type_o = DATA_WORD;
					default: illegal_o = 1'b1;
				endcase
			end
			OPCODE_OP_IMM: begin
				rf_we_o = 1'b1;
				case (funct3)
					3'b000: alu_operator_o = ALU_ADD;
					3'b010: alu_operator_o = ALU_SLT;
					3'b011: alu_operator_o = ALU_SLTU;
					3'b100: alu_operator_o = ALU_XOR;
					3'b110: alu_operator_o = ALU_OR;
					3'b111: alu_operator_o = ALU_AND;
					3'b001: begin
						alu_operator_o = ALU_SLL;
						illegal_o      = (funct7 != 7'b0000000);
					end
					default: begin
						if (funct7 == 7'b0000000) begin
							alu_operator_o = ALU_SRL;
						end else if (funct7 == 7'b0100000) begin
							alu_operator_o = ALU_SRA;
						end else begin
							illegal_o = 1'b1;
						end
					end
				endcase
			end
			OPCODE_OP: begin
				rf_we_o    = 1'b1;
				op_b_sel_o = OP_B_REG_B;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: alu_operator_o = ALU_ADD;
					{7'b0100000, 3'b000}: alu_operator_o = ALU_SUB;
					{7'b0000000, 3'b001}: alu_operator_o = ALU_SLL;
					{7'b0000000, 3'b010}: alu_operator_o = ALU_SLT;
					{7'b0000000, 3'b011}: alu_operator_o = ALU_SLTU;
					{7'b0000000, 3'b100}: alu_operator_o = ALU_XOR;
					{7'b0000000, 3'b101}: alu_operator_o = ALU_SRL;
					{7'b0100000, 3'b101}: alu_operator_o = ALU_SRA;
					{7'b0000000, 3'b110}: alu_operator_o = ALU_OR;
					{7'b0000000, 3'b111}: alu_operator_o = ALU_AND;
					default:              illegal_o = 1'b1;
				endcase
			end
			default: illegal_o = 1'b1;
		endcase

		// Nothing of an illegal word may take effect.
		if (illegal_o) begin
			rf_we_o    = 1'b0;
			data_req_o = 1'b0;
			data_we_o  = 1'b0;
			branch_o   = 1'b0;
			jump_o     = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- id_multicycle_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module id_multicycle_fsm (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic instr_new_i,
	input  logic data_req_dec_i,
	input  logic branch_dec_i,
	input  logic jump_dec_i,
	input  logic rf_we_dec_i,
	input  logic illegal_i,
	input  logic branch_decision_i,
	input  logic ex_valid_i,
	input  logic lsu_valid_i,
	input  logic lsu_load_err_i,
	output logic rf_we_o,
	output logic data_req_o,
	output logic ready_o,
	output logic branch_set_o,
	output logic instr_ret_o
);
	import id_pkg::*;

	id_fsm_e state_q;
	id_fsm_e state_d;
	logic    done_q;
	logic    done_d;
	logic    branch_set_d;
	logic    instr_multicycle;
	logic    instr_executing;
	logic    rf_we_wb;
	logic    stall;

	assign instr_multicycle = data_req_dec_i | branch_dec_i | jump_dec_i;

	// A multicycle instruction keeps executing until its done flag is set.
	assign instr_executing = instr_new_i | (instr_multicycle & ~done_q);

	always_comb begin
		state_d      = state_q;
		done_d       = done_q;
		rf_we_wb     = 1'b0;
		stall        = 1'b0;
		branch_set_d = 1'b0;
		instr_ret_o  = 1'b0;

		case (state_q)
			IDLE: begin
				if (instr_new_i) begin
					if (illegal_i) begin
						done_d = 1'b1;
					end else if (data_req_dec_i | jump_dec_i) begin
						state_d = WAIT_MULTICYCLE;
						stall   = 1'b1;
						done_d  = 1'b0;
					end else if (branch_dec_i) begin
						state_d      = branch_decision_i ? WAIT_MULTICYCLE : IDLE;
						stall        = branch_decision_i;
						done_d       = ~branch_decision_i;
						branch_set_d = branch_decision_i;
						instr_ret_o  = ~branch_decision_i;
					end else begin
						done_d      = 1'b1;
						instr_ret_o = 1'b1;
					end
				end
			end
			WAIT_MULTICYCLE: begin
				if ((data_req_dec_i & lsu_valid_i) | (~data_req_dec_i & ex_valid_i)) begin
					state_d     = IDLE;
					done_d      = 1'b1;
					rf_we_wb    = rf_we_dec_i & ~(data_req_dec_i & lsu_load_err_i);
					instr_ret_o = 1'b1;
				end else begin
					stall = 1'b1;
				end
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q      <= IDLE;
			done_q       <= 1'b1;
			branch_set_o <= 1'b0;
		end else begin
			state_q      <= state_d;
			done_q       <= done_d;
			branch_set_o <= branch_set_d;
		end
	end

	// Multicycle instructions write back only when they complete.
	assign rf_we_o    = ~illegal_i & instr_executing &
	                    (instr_multicycle ? rf_we_wb : rf_we_dec_i);
	assign data_req_o = ~illegal_i & instr_executing & data_req_dec_i;
	assign ready_o    = ~stall;

endmodule

`default_nettype wire

//--- id_operand_mux.sv
`timescale 1ns/1ps
`default_nettype none

module id_operand_mux (
	input  id_pkg::op_a_sel_e  op_a_sel_i,
	input  id_pkg::op_b_sel_e  op_b_sel_i,
	input  id_pkg::imm_b_sel_e imm_b_sel_i,
	input  id_pkg::xlen_t      imm_i_i,
	input  id_pkg::xlen_t      imm_s_i,
	input  id_pkg::xlen_t      imm_b_i,
	input  id_pkg::xlen_t      imm_u_i,
	input  id_pkg::xlen_t      imm_j_i,
	input  id_pkg::xlen_t      rdata_a_i,
	input  id_pkg::xlen_t      rdata_b_i,
	input  id_pkg::xlen_t      pc_i,
	output id_pkg::xlen_t      operand_a_o,
	output id_pkg::xlen_t      operand_b_o
);
	import id_pkg::*;

	xlen_t imm_b;

	always_comb begin
		case (op_a_sel_i)
			OP_A_CURRPC: operand_a_o = pc_i;
			OP_A_ZERO:   operand_a_o = '0;
			default:     operand_a_o = rdata_a_i;
		endcase
	end

	always_comb begin
		case (imm_b_sel_i)
			IMM_B_I: imm_b = imm_i_i;
			IMM_B_S: imm_b = imm_s_i;
			IMM_B_B: imm_b = imm_b_i;
			IMM_B_U: imm_b = imm_u_i;
			IMM_B_J: imm_b = imm_j_i;
			default: imm_b = PC_INCR;
		endcase
	end

	assign operand_b_o = (op_b_sel_i == OP_B_IMM) ? imm_b : rdata_b_i;

endmodule

`default_nettype wire

//--- id_pkg.sv
`default_nettype none

package id_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [6:0]  opcode_t;

	// Major opcodes, RV32I base set only.
	localparam opcode_t OPCODE_LOAD   = 7'h03;
	localparam opcode_t OPCODE_OP_IMM = 7'h13;
	localparam opcode_t OPCODE_AUIPC  = 7'h17;
	localparam opcode_t OPCODE_STORE  = 7'h23;
	localparam opcode_t OPCODE_OP     = 7'h33;
	localparam opcode_t OPCODE_LUI    = 7'h37;
	localparam opcode_t OPCODE_BRANCH = 7'h63;
	localparam opcode_t OPCODE_JALR   = 7'h67;
	localparam opcode_t OPCODE_JAL    = 7'h6f;

	typedef enum logic [4:0] {
		ALU_ADD  = 5'd0,
		ALU_SUB  = 5'd1,
		ALU_XOR  = 5'd2,
		ALU_OR   = 5'd3,
		ALU_AND  = 5'd4,
		ALU_SRA  = 5'd5,
		ALU_SRL  = 5'd6,
		ALU_SLL  = 5'd7,
		ALU_LT   = 5'd8,
		ALU_LTU  = 5'd9,
		ALU_GE   = 5'd10,
		ALU_GEU  = 5'd11,
		ALU_EQ   = 5'd12,
		ALU_NE   = 5'd13,
		ALU_SLT  = 5'd14,
		ALU_SLTU = 5'd15
	} alu_op_e;

	typedef enum logic [1:0] {
		OP_A_REG_A  = 2'd0,
		OP_A_CURRPC = 2'd2,
		OP_A_ZERO   = 2'd3
	} op_a_sel_e;

	typedef enum logic [0:0] {
		OP_B_REG_B = 1'b0,
		OP_B_IMM   = 1'b1
	} op_b_sel_e;

	typedef enum logic [2:0] {
		IMM_B_I       = 3'd0,
		IMM_B_S       = 3'd1,
		IMM_B_B       = 3'd2,
		IMM_B_U       = 3'd3,
		IMM_B_J       = 3'd4,
		IMM_B_INCR_PC = 3'd5
	} imm_b_sel_e;

	typedef enum logic [0:0] {
		RF_WD_LSU = 1'b0,
		RF_WD_EX  = 1'b1
	} rf_wd_sel_e;

	typedef logic [1:0] data_type_t;

	localparam data_type_t DATA_WORD = 2'b00;
	localparam data_type_t DATA_HALF = 2'b01;
	localparam data_type_t DATA_BYTE = 2'b10;

	typedef enum logic [0:0] {
		IDLE            = 1'b0,
		WAIT_MULTICYCLE = 1'b1
	} id_fsm_e;

	localparam xlen_t PC_INCR = 32'd4;

endpackage

`default_nettype wire

//--- id_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module id_regfile (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  id_pkg::reg_addr_t  raddr_a_i,
	input  id_pkg::reg_addr_t  raddr_b_i,
	input  id_pkg::reg_addr_t  waddr_i,
	input  logic               we_i,
	input  id_pkg::rf_wd_sel_e wdata_sel_i,
	input  id_pkg::xlen_t      wdata_ex_i,
	input  id_pkg::xlen_t      wdata_lsu_i,
	output id_pkg::xlen_t      rdata_a_o,
	output id_pkg::xlen_t      rdata_b_o
);
	import id_pkg::*;

	// Only x1 to x31 are stored.
	xlen_t mem_q [1:31];
	xlen_t wdata;

	assign wdata = (wdata_sel_i == RF_WD_LSU) ? wdata_lsu_i : wdata_ex_i;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 1; i < 32; i++) begin
				mem_q[i] <= '0;
			end
		end else if (we_i && (waddr_i != 5'd0)) begin
			mem_q[waddr_i] <= wdata;
		end
	end

	assign rdata_a_o = (raddr_a_i == 5'd0) ? '0 : mem_q[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == 5'd0) ? '0 : mem_q[raddr_b_i];

endmodule

`default_nettype wire

//--- id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               instr_valid_i,
	input  logic               instr_new_i,
	input  id_pkg::instr_t     instr_rdata_i,
	input  id_pkg::xlen_t      pc_id_i,
	input  logic               branch_decision_i,
	input  logic               ex_valid_i,
	input  logic               lsu_valid_i,
	input  logic               lsu_load_err_i,
	input  id_pkg::xlen_t      regfile_wdata_ex_i,
	input  id_pkg::xlen_t      regfile_wdata_lsu_i,
	output logic               illegal_insn_o,
	output logic               id_in_ready_o,
	output logic               branch_set_o,
	output logic               instr_ret_o,
	output id_pkg::alu_op_e    alu_operator_o,
	output id_pkg::xlen_t      alu_operand_a_o,
	output id_pkg::xlen_t      alu_operand_b_o,
	output logic               data_req_o,
	output logic               data_we_o,
	output id_pkg::data_type_t data_type_o,
	output logic               data_sign_ext_o,
	output id_pkg::xlen_t      data_wdata_o
);
	import id_pkg::*;

	logic       illegal_dec;
	reg_addr_t  raddr_a;
	reg_addr_t  raddr_b;
	reg_addr_t  waddr;
	logic       rf_we_dec;
	logic       rf_we;
	rf_wd_sel_e wdata_sel;
	op_a_sel_e  op_a_sel;
	op_b_sel_e  op_b_sel;
	imm_b_sel_e imm_b_sel;
	xlen_t      imm_i;
	xlen_t      imm_s;
	xlen_t      imm_b;
	xlen_t      imm_u;
	xlen_t      imm_j;
	xlen_t      rdata_a;
	xlen_t      rdata_b;
	logic       data_req_dec;
	logic       branch_dec;
	logic       jump_dec;

	id_decoder decoder_i (
		.instr_rdata_i   (instr_rdata_i),
		.illegal_o       (illegal_dec),
		.raddr_a_o       (raddr_a),
		.raddr_b_o       (raddr_b),
		.waddr_o         (waddr),
		.rf_we_o         (rf_we_dec),
		.wdata_sel_o     (wdata_sel),
		.alu_operator_o  (alu_operator_o),
		.op_a_sel_o      (op_a_sel),
		.op_b_sel_o      (op_b_sel),
		.imm_b_sel_o     (imm_b_sel),
		.imm_i_o         (imm_i),
		.imm_s_o         (imm_s),
		.imm_b_o         (imm_b),
		.imm_u_o         (imm_u),
		.imm_j_o         (imm_j),
		.data_req_o      (data_req_dec),
		.data_we_o       (data_we_o),
		.data_type_o     (data_type_o),
		.data_sign_ext_o (data_sign_ext_o),
		.branch_o        (branch_dec),
		.jump_o          (jump_dec)
	);

	id_regfile regfile_i (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.raddr_a_i   (raddr_a),
		.raddr_b_i   (raddr_b),
		.waddr_i     (waddr),
		.we_i        (rf_we),
		.wdata_sel_i (wdata_sel),
		.wdata_ex_i  (regfile_wdata_ex_i),
		.wdata_lsu_i (regfile_wdata_lsu_i),
		.rdata_a_o   (rdata_a),
		.rdata_b_o   (rdata_b)
	);

	id_operand_mux operand_mux_i (
		.op_a_sel_i  (op_a_sel),
		.op_b_sel_i  (op_b_sel),
		.imm_b_sel_i (imm_b_sel),
		.imm_i_i     (imm_i),
		.imm_s_i     (imm_s),
		.imm_b_i     (imm_b),
		.imm_u_i     (imm_u),
		.imm_j_i     (imm_j),
		.rdata_a_i   (rdata_a),
		.rdata_b_i   (rdata_b),
		.pc_i        (pc_id_i),
		.operand_a_o (alu_operand_a_o),
		.operand_b_o (alu_operand_b_o)
	);

	// Decode of a stale word is not an illegal instruction.
	assign illegal_insn_o = instr_valid_i & illegal_dec;

	id_multicycle_fsm fsm_i (
		.clk_i             (clk_i),
		.rst_ni            (rst_ni),
		.instr_new_i       (instr_new_i),
		.data_req_dec_i    (data_req_dec),
		.branch_dec_i      (branch_dec),
		.jump_dec_i        (jump_dec),
		.rf_we_dec_i       (rf_we_dec),
		.illegal_i         (illegal_insn_o),
		.branch_decision_i (branch_decision_i),
		.ex_valid_i        (ex_valid_i),
		.lsu_valid_i       (lsu_valid_i),
		.lsu_load_err_i    (lsu_load_err_i),
		.rf_we_o           (rf_we),
		.data_req_o        (data_req_o),
		.ready_o           (id_in_ready_o),
		.branch_set_o      (branch_set_o),
		.instr_ret_o       (instr_ret_o)
	);

	assign data_wdata_o = rdata_b;

endmodule

`default_nettype wire

//--- id_stage_props.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_props (
	input logic            clk_i,
	input logic            rst_ni,
	input logic            instr_new_i,
	input logic            branch_decision_i,
	input logic            ex_valid_i,
	input logic            lsu_valid_i,
	input logic            branch_dec_i,
	input logic            rf_we_i,
	input id_pkg::id_fsm_e state_i,
	input logic            data_req_i,
	input logic            id_in_ready_i,
	input logic            branch_set_i,
	input logic            instr_ret_i
);
	import id_pkg::*;

	// Quiet outputs in reset and on the first cycle after it.
	a_reset_quiet: assert property (@(posedge clk_i) (!rst_ni || $rose(rst_ni)) |->
		(state_i == IDLE) && !branch_set_i && !instr_ret_i && !data_req_i && !rf_we_i &&
		id_in_ready_i)
		else $error("stage not quiet around reset");

	a_req_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(state_i == IDLE && !instr_new_i) |-> !data_req_i)
		else $error("data request in IDLE without a new instruction");

	a_bset_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
		branch_set_i |-> $past(instr_new_i && branch_dec_i && branch_decision_i))
		else $error("branch_set_o without a taken branch in the previous cycle");

	a_bset_follow: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(state_i == IDLE && instr_new_i && branch_dec_i && branch_decision_i) |=> branch_set_i)
		else $error("taken branch not followed by branch_set_o");

	// The completion cycle of a wait already shows ready.
	a_wait_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(state_i == WAIT_MULTICYCLE && !lsu_valid_i && !ex_valid_i) |-> !id_in_ready_i)
		else $error("id_in_ready_o high while waiting on a multicycle instruction");

endmodule

bind id_stage id_stage_props props_i (
	.clk_i             (clk_i),
	.rst_ni            (rst_ni),
	.instr_new_i       (instr_new_i),
	.branch_decision_i (branch_decision_i),
	.ex_valid_i        (ex_valid_i),
	.lsu_valid_i       (lsu_valid_i),
	.branch_dec_i      (branch_dec),
	.rf_we_i           (rf_we),
	.state_i           (fsm_i.state_q),
	.data_req_i        (data_req_o),
	.id_in_ready_i     (id_in_ready_o),
	.branch_set_i      (branch_set_o),
	.instr_ret_i       (instr_ret_o)
);

`default_nettype wire

//--- tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
	import id_pkg::*;

	// Iterations of the test sequence and the longest iteration in cycles.
	localparam int N_ITER      = 50;
	localparam int ITER_CYCLES = 42;
	localparam int TIMEOUT     = 2 * (N_ITER * ITER_CYCLES + 6) + 100;

	logic       clk_i;
	logic       rst_ni;
	logic       instr_valid_i;
	logic       instr_new_i;
	instr_t     instr_rdata_i;
	xlen_t      pc_id_i;
	logic       branch_decision_i;
	logic       ex_valid_i;
	logic       lsu_valid_i;
	logic       lsu_load_err_i;
	xlen_t      regfile_wdata_ex_i;
	xlen_t      regfile_wdata_lsu_i;
	logic       illegal_insn_o;
	logic       id_in_ready_o;
	logic       branch_set_o;
	logic       instr_ret_o;
	alu_op_e    alu_operator_o;
	xlen_t      alu_operand_a_o;
	xlen_t      alu_operand_b_o;
	logic       data_req_o;
	logic       data_we_o;
	data_type_t data_type_o;
	logic       data_sign_ext_o;
	xlen_t      data_wdata_o;

	// Expected responses for the current cycle.
	logic       exp_ready;
	logic       exp_ret;
	logic       exp_req;
	logic       exp_illegal;
	logic       exp_bset;
	logic       exp_sext;
	logic       chk_ops;
	logic       chk_wdata;
	logic       chk_store;
	logic       chk_load;
	xlen_t      exp_a;
	xlen_t      exp_b;
	xlen_t      exp_wdata;
	alu_op_e    exp_op;
	data_type_t exp_type;

	xlen_t      model [32];
	xlen_t      pc;
	integer     seed;
	int         errors = 0;
	int         cycle_count = 0;
	int         instr_count = 0;

	id_stage id_stage_i (.*);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp_val,
	                               input logic [31:0] act_val);
		errors++;
		$display("mismatch at %0t: %s expected %h, actual %h", $time, name, exp_val, act_val);
	endtask

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic xlen_t sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic alu_op_e compare_op(input logic [2:0] f3);
		case (f3)
			3'b000:  return ALU_EQ;
			3'b001:  return ALU_NE;
			3'b100:  return ALU_LT;
			3'b101:  return ALU_GE;
			3'b110:  return ALU_LTU;
			default: return ALU_GEU;
		endcase
	endfunction

	// Outputs are sampled at the falling edge, 1 ns after the inputs change.
	a_ready: assert property (@(negedge clk_i) disable iff (!rst_ni) id_in_ready_o == exp_ready)
		else report_mismatch("id_in_ready_o", 32'(exp_ready), 32'(id_in_ready_o));
	a_ret: assert property (@(negedge clk_i) disable iff (!rst_ni) instr_ret_o == exp_ret)
		else report_mismatch("instr_ret_o", 32'(exp_ret), 32'(instr_ret_o));
	a_req: assert property (@(negedge clk_i) disable iff (!rst_ni) data_req_o == exp_req)
		else report_mismatch("data_req_o", 32'(exp_req), 32'(data_req_o));
	a_illegal: assert property (@(negedge clk_i) disable iff (!rst_ni)
		illegal_insn_o == exp_illegal)
		else report_mismatch("illegal_insn_o", 32'(exp_illegal), 32'(illegal_insn_o));
	a_bset: assert property (@(negedge clk_i) disable iff (!rst_ni) branch_set_o == exp_bset)
		else report_mismatch("branch_set_o", 32'(exp_bset), 32'(branch_set_o));
	a_op_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
		chk_ops |-> alu_operand_a_o == exp_a)
		else report_mismatch("alu_operand_a_o", exp_a, alu_operand_a_o);
	a_op_b: assert property (@(negedge clk_i) disable iff (!rst_ni)
		chk_ops |-> alu_operand_b_o == exp_b)
		else report_mismatch("alu_operand_b_o", exp_b, alu_operand_b_o);
	a_alu_op: assert property (@(negedge clk_i) disable iff (!rst_ni)
		chk_ops |-> alu_operator_o == exp_op)
		else report_mismatch("alu_operator_o", 32'(exp_op), 32'(alu_operator_o));
	a_wdata: assert property (@(negedge clk_i) disable iff (!rst_ni)
		chk_wdata |-> data_wdata_o == exp_wdata)
		else report_mismatch("data_wdata_o", exp_wdata, data_wdata_o);
	a_we: assert property (@(negedge clk_i) disable iff (!rst_ni) chk_store |-> data_we_o)
		else report_mismatch("data_we_o", 32'd1, 32'(data_we_o));
	a_type: assert property (@(negedge clk_i) disable iff (!rst_ni)
		(chk_store || chk_load) |-> data_type_o == exp_type)
		else report_mismatch("data_type_o", 32'(exp_type), 32'(data_type_o));
	a_sext: assert property (@(negedge clk_i) disable iff (!rst_ni)
		chk_load |-> data_sign_ext_o == exp_sext)
		else report_mismatch("data_sign_ext_o", 32'(exp_sext), 32'(data_sign_ext_o));

	task automatic clear_cycle();
		instr_new_i       = 1'b0;
		branch_decision_i = 1'b0;
		ex_valid_i        = 1'b0;
		lsu_valid_i       = 1'b0;
		lsu_load_err_i    = 1'b0;
		exp_ready         = 1'b1;
		exp_ret           = 1'b0;
		exp_req           = 1'b0;
		exp_illegal       = 1'b0;
		exp_bset          = 1'b0;
		chk_ops           = 1'b0;
		chk_wdata         = 1'b0;
		chk_store         = 1'b0;
		chk_load          = 1'b0;
	endtask

	task automatic next_cycle();
		@(posedge clk_i);
		#1;
		clear_cycle();
	endtask

	task automatic write_model(input reg_addr_t rd, input xlen_t val);
		if (rd != 5'd0) begin
			model[rd] = val;
		end
	endtask

	// ADD x0, r, r without instr_new_i shows register r on both read ports.
	task automatic read_back(input reg_addr_t r);
		next_cycle();
		instr_rdata_i = {7'h00, r, r, 3'b000, 5'd0, OPCODE_OP};
		chk_ops       = 1'b1;
		chk_wdata     = 1'b1;
		exp_a         = model[r];
		exp_b         = model[r];
		exp_op        = ALU_ADD;
		exp_wdata     = model[r];
	endtask

	// The PC advances before the word is shown.
	task automatic issue(input instr_t instr, input xlen_t a, input xlen_t b,
	                     input alu_op_e op);
		next_cycle();
		pc            = pc + PC_INCR;
		pc_id_i       = pc;
		instr_rdata_i = instr;
		instr_new_i   = 1'b1;
		chk_ops       = 1'b1;
		exp_a         = a;
		exp_b         = b;
		exp_op        = op;
		instr_count++;
	endtask

	task automatic wait_done(input logic mem, input logic taken, input logic err);
		logic [31:0] r;
		int          delay;
		r     = rand_word();
		delay = int'(r[1:0]);
		for (int i = 0; i <= delay; i++) begin
			next_cycle();
			exp_req  = mem;
			exp_bset = taken && (i == 0);
			if (i == delay) begin
				lsu_valid_i    = mem;
				ex_valid_i     = ~mem;
				lsu_load_err_i = err;
				exp_ret        = 1'b1;
			end else begin
				exp_ready = 1'b0;
			end
		end
	endtask

	task automatic single_cycle(input instr_t instr, input xlen_t a, input xlen_t b,
	                            input alu_op_e op);
		xlen_t result;
		result = rand_word();
		issue(instr, a, b, op);
		regfile_wdata_ex_i = result;
		exp_ret            = 1'b1;
		write_model(instr[11:7], result);
		read_back(instr[11:7]);
	endtask

	task automatic test_alu();
		logic [31:0] r;
		logic [31:0] u;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		reg_addr_t   rd;
		r   = rand_word();
		u   = rand_word();
		rs1 = r[4:0];
		rs2 = r[9:5];
		rd  = r[14:10];
		single_cycle({r[31:20], rs1, 3'b000, rd, OPCODE_OP_IMM}, model[rs1],
		             sext12(r[31:20]), ALU_ADD);
		single_cycle({7'h00, rs2, rs1, 3'b000, rd + 5'd1, OPCODE_OP}, model[rs1], model[rs2],
		             ALU_ADD);
		single_cycle({7'h20, rs2, rs1, 3'b000, rd + 5'd2, OPCODE_OP}, model[rs1], model[rs2],
		             ALU_SUB);
		single_cycle({u[19:0], rd + 5'd3, OPCODE_LUI}, '0, {u[19:0], 12'b0}, ALU_ADD);
		single_cycle({u[31:12], rd + 5'd4, OPCODE_AUIPC}, pc + PC_INCR, {u[31:12], 12'b0},
		             ALU_ADD);
	endtask

	task automatic test_load();
		logic [31:0] r;
		logic [31:0] data;
		logic [2:0]  f3;
		r    = rand_word();
		data = rand_word();
		f3   = (r[1:0] == 2'b11) ? 3'b100 : {1'b0, r[1:0]};
		issue({r[31:20], r[19:15], f3, r[11:7], OPCODE_LOAD}, model[r[19:15]],
		      sext12(r[31:20]), ALU_ADD);
		regfile_wdata_lsu_i = data;
		exp_ready           = 1'b0;
		exp_req             = 1'b1;
		chk_load            = 1'b1;
		// Only LBU zero-extends among the loads issued here.
		exp_sext            = (f3 != 3'b100);
		exp_type = ((f3 == 3'b000) || (f3 == 3'b100)) ? DATA_BYTE :
		           (f3 == 3'b001) ? DATA_HALF : DATA_WORD;
		wait_done(1'b1, 1'b0, r[2]);
		if (!r[2]) begin
			write_model(r[11:7], data);
		end
		read_back(r[11:7]);
	endtask

	task automatic test_store();
		logic [31:0] r;
		logic [2:0]  f3;
		r  = rand_word();
		f3 = (r[1:0] == 2'b11) ? 3'b010 : {1'b0, r[1:0]};
		issue({r[31:25], r[24:20], r[19:15], f3, r[11:7], OPCODE_STORE}, model[r[19:15]],
		      sext12({r[31:25], r[11:7]}), ALU_ADD);
		regfile_wdata_lsu_i = rand_word();
		exp_ready           = 1'b0;
		exp_req             = 1'b1;
		chk_store           = 1'b1;
		chk_wdata           = 1'b1;
		exp_wdata           = model[r[24:20]];
		exp_type = (f3 == 3'b000) ? DATA_BYTE : (f3 == 3'b001) ? DATA_HALF : DATA_WORD;
		wait_done(1'b1, 1'b0, 1'b0);
		read_back(r[11:7]);
	endtask

	task automatic test_branch();
		logic [31:0] r;
		logic [2:0]  f3;
		r  = rand_word();
		f3 = (r[14:13] == 2'b01) ? {2'b00, r[12]} : r[14:12];
		issue({r[31:25], r[24:20], r[19:15], f3, r[11:7], OPCODE_BRANCH}, model[r[19:15]],
		      model[r[24:20]], compare_op(f3));
		branch_decision_i = r[0];
		exp_ready         = ~r[0];
		exp_ret           = ~r[0];
		if (r[0]) begin
			wait_done(1'b0, 1'b1, 1'b0);
		end
	endtask

	task automatic test_jump(input logic jalr);
		logic [31:0] r;
		logic [31:0] data;
		instr_t      instr;
		r     = rand_word();
		data  = rand_word();
		instr = jalr ? {r[31:20], r[19:15], 3'b000, r[11:7], OPCODE_JALR}
		             : {r[31:12], r[11:7], OPCODE_JAL};
		issue(instr, pc + PC_INCR, PC_INCR, ALU_ADD);
		regfile_wdata_ex_i = data;
		exp_ready          = 1'b0;
		wait_done(1'b0, 1'b0, 1'b0);
		write_model(r[11:7], data);
		read_back(r[11:7]);
	endtask

	// Opcode 7'h0b is outside the decoded set.
	task automatic test_illegal();
		logic [31:0] r;
		r = rand_word();
		issue({r[31:7], 7'h0b}, '0, '0, ALU_ADD);
		chk_ops            = 1'b0;
		exp_illegal        = 1'b1;
		regfile_wdata_ex_i = rand_word();
		// The same word without instr_valid_i is not flagged.
		next_cycle();
		instr_valid_i = 1'b0;
		read_back(r[11:7]);
		instr_valid_i = 1'b1;
	endtask

	initial begin
		seed                = 32'h73f0;
		pc                  = 32'h0000_1000;
		rst_ni              = 1'b0;
		instr_valid_i       = 1'b0;
		instr_rdata_i       = 32'h0000_0013;
		pc_id_i             = '0;
		regfile_wdata_ex_i  = '0;
		regfile_wdata_lsu_i = '0;
		exp_a               = '0;
		exp_b               = '0;
		exp_wdata           = '0;
		exp_op              = ALU_ADD;
		exp_type            = DATA_WORD;
		exp_sext            = 1'b0;
		clear_cycle();
		for (int i = 0; i < 32; i++) begin
			model[i] = '0;
		end
		repeat (3) @(posedge clk_i);
		#1;
		rst_ni        = 1'b1;
		instr_valid_i = 1'b1;
		next_cycle();
		for (int n = 0; n < N_ITER; n++) begin
			test_alu();
			test_load();
			test_store();
			test_branch();
			test_jump(1'b0);
			test_jump(1'b1);
			test_illegal();
		end
		@(negedge clk_i);
		#1;
		$display("%0d instructions, %0d cycles, %0d errors", instr_count, cycle_count, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		while (cycle_count < TIMEOUT) begin
			@(posedge clk_i);
			cycle_count++;
		end
		$display("timeout: the test sequence did not end within %0d cycles", TIMEOUT);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
